// File: common/cpu_pkg.sv
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_addr_t;
    typedef logic [3:0] alu_op_t;

    // one instruction word, decoded as r-type or i-type
    typedef union packed {
        struct packed {
            logic [5:0] op;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0] op;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [15:0] imm;
        } i;
    } instr_t;

    // primary opcodes
    localparam logic [5:0] op_special = 6'h00, op_j = 6'h02, op_jal = 6'h03,
        op_beq = 6'h04, op_bne = 6'h05, op_addi = 6'h08, op_addiu = 6'h09,
        op_slti = 6'h0a, op_sltiu = 6'h0b, op_andi = 6'h0c, op_ori = 6'h0d,
        op_xori = 6'h0e, op_lui = 6'h0f, op_lw = 6'h23, op_sw = 6'h2b;

    // function field of op_special
    localparam logic [5:0] fn_sll = 6'h00, fn_srl = 6'h02, fn_sra = 6'h03,
        fn_sllv = 6'h04, fn_srlv = 6'h06, fn_srav = 6'h07, fn_jr = 6'h08,
        fn_mfhi = 6'h10, fn_mflo = 6'h12, fn_mult = 6'h18, fn_multu = 6'h19,
        fn_div = 6'h1a, fn_divu = 6'h1b, fn_add = 6'h20, fn_addu = 6'h21,
        fn_sub = 6'h22, fn_subu = 6'h23, fn_and = 6'h24, fn_or = 6'h25,
        fn_xor = 6'h26, fn_nor = 6'h27, fn_slt = 6'h2a, fn_sltu = 6'h2b;

    localparam alu_op_t alu_add = 4'd0, alu_sub = 4'd1, alu_slt = 4'd2,
        alu_sltu = 4'd3, alu_and = 4'd4, alu_or = 4'd5, alu_xor = 4'd6,
        alu_nor = 4'd7, alu_sll = 4'd8, alu_srl = 4'd9, alu_sra = 4'd10,
        alu_eq = 4'd11, alu_mul = 4'd12;

    // sequencer states
    localparam logic [2:0] st_idle = 3'd0, st_fetch = 3'd1, st_decode = 3'd2,
        st_exec = 3'd3, st_div_wait = 3'd4, st_writeback = 3'd5;

    localparam word_t text_base = 32'h0040_0000;
    localparam int imem_words = 256;
    localparam int imem_addr_w = 8;
    localparam int dmem_words = 1024;

    localparam reg_addr_t ctrl_reg = 5'd27;
    localparam int halt_bit = 3;
    localparam reg_addr_t sp_reg = 5'd29;
    localparam word_t sp_init = 32'h7fff_effc;

    localparam int div_cycles = 32;

endpackage

// File: common/exec_if.sv
`timescale 1ns/100ps

interface exec_if;
    import cpu_pkg::*;

    // issued by control
    alu_op_t alu_op;
    word_t operand_a;
    word_t operand_b;
    logic div_start;
    logic div_signed;

    // alu results
    word_t alu_result;
    word_t mul_hi;
    logic overflow;

    // divider results
    word_t quotient;
    word_t remainder;
    logic div_done;

    modport ctrl (
        output alu_op, operand_a, operand_b, div_start, div_signed,
        input alu_result, mul_hi, overflow, quotient, remainder, div_done
    );
    modport alu (input alu_op, operand_a, operand_b, output alu_result, mul_hi, overflow);
    modport div (input operand_a, operand_b, div_start, div_signed,
                 output quotient, remainder, div_done);
endinterface

// File: logic/register_file.sv
`timescale 1ns/100ps

module register_file (
    input  logic                clk,
    input  logic                reset,
    input  cpu_pkg::reg_addr_t  rs_addr,
    input  cpu_pkg::reg_addr_t  rt_addr,
    output cpu_pkg::word_t      rs_data,
    output cpu_pkg::word_t      rt_data,
    input  logic                wr_en,
    input  cpu_pkg::reg_addr_t  wr_addr,
    input  cpu_pkg::word_t      wr_data,
    input  cpu_pkg::reg_addr_t  dbg_addr,
    output cpu_pkg::word_t      dbg_data,
    output cpu_pkg::word_t      ctrl_word
);
    import cpu_pkg::*;

    word_t regs [32];

    // asynchronous reads
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];
    assign dbg_data = regs[dbg_addr];
    assign ctrl_word = regs[ctrl_reg];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int n = 0; n < 32; n++) begin
                regs[n] <= '0;
            end
            regs[sp_reg] <= sp_init;
        end else if (wr_en && wr_addr != '0) begin
            // r0 stays zero
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

// File: logic/alu.sv
`timescale 1ns/100ps

module alu (
    exec_if.alu ex
);
    import cpu_pkg::*;

    word_t sum;
    word_t diff;
    logic signed [63:0] product;

    assign sum = ex.operand_a + ex.operand_b;
    assign diff = ex.operand_a - ex.operand_b;
    assign product = $signed(ex.operand_a) * $signed(ex.operand_b);
    assign ex.mul_hi = product[63:32];

    always_comb begin
        ex.overflow = 1'b0;
        case (ex.alu_op)
            alu_add: begin
                ex.alu_result = sum;
                ex.overflow = (ex.operand_a[31] == ex.operand_b[31])
                            && (sum[31] != ex.operand_a[31]);
            end
            alu_sub: begin
                ex.alu_result = diff;
                ex.overflow = (ex.operand_a[31] != ex.operand_b[31])
                            && (diff[31] != ex.operand_a[31]);
            end
            alu_slt: ex.alu_result = {31'h0, $signed(ex.operand_a) < $signed(ex.operand_b)};
            alu_sltu: ex.alu_result = {31'h0, ex.operand_a < ex.operand_b};
            alu_and: ex.alu_result = ex.operand_a & ex.operand_b;
            alu_or: ex.alu_result = ex.operand_a | ex.operand_b;
            alu_xor: ex.alu_result = ex.operand_a ^ ex.operand_b;
            alu_nor: ex.alu_result = ~(ex.operand_a | ex.operand_b);
            // shifts move operand_b by the low five bits of operand_a
            alu_sll: ex.alu_result = ex.operand_b << ex.operand_a[4:0];
            alu_srl: ex.alu_result = ex.operand_b >> ex.operand_a[4:0];
            alu_sra: ex.alu_result = word_t'($signed(ex.operand_b) >>> ex.operand_a[4:0]);
            alu_eq: ex.alu_result = {31'h0, ex.operand_a == ex.operand_b};
            alu_mul: ex.alu_result = product[31:0];
            default: ex.alu_result = '0;
        endcase
    end

endmodule

// File: logic/divider.sv
`timescale 1ns/100ps

module divider (
    input logic clk,
    input logic reset,
    exec_if.div ex
);
    import cpu_pkg::*;

    logic busy;
    logic [$clog2(div_cycles)-1:0] count;
    word_t quo;
    word_t rem;
    word_t dvs;
    logic neg_q;
    logic neg_r;
    logic a_neg;
    logic b_neg;
    logic [33:0] trial;

    assign a_neg = ex.div_signed && ex.operand_a[31];
    assign b_neg = ex.div_signed && ex.operand_b[31];

    // shift in the next dividend bit and try the subtract
    assign trial = {1'b0, rem, quo[31]} - {2'b00, dvs};

    // restore signs on the magnitudes
    assign ex.quotient = neg_q ? -quo : quo;
    assign ex.remainder = neg_r ? -rem : rem;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            count <= '0;
            ex.div_done <= 1'b0;
        end else begin
            ex.div_done <= 1'b0;
            if (busy) begin
                count <= count + 1'b1;
                if (count == div_cycles - 1) begin
                    busy <= 1'b0;
                    ex.div_done <= 1'b1;
                end
            end else if (ex.div_start) begin
                busy <= 1'b1;
                count <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && ex.div_start) begin
            quo <= a_neg ? -ex.operand_a : ex.operand_a;
            dvs <= b_neg ? -ex.operand_b : ex.operand_b;
            rem <= '0;
            // zero divisor keeps the all-ones quotient
            neg_q <= (a_neg ^ b_neg) && (ex.operand_b != '0);
            neg_r <= a_neg;
        end else if (busy) begin
            if (!trial[33]) begin
                rem <= trial[31:0];
                quo <= {quo[30:0], 1'b1};
            end else begin
                rem <= {rem[30:0], quo[31]};
                quo <= {quo[30:0], 1'b0};
            end
        end
    end

endmodule

// File: core/cpu_control.sv
`timescale 1ns/100ps

module cpu_control (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             load_en,
    input  logic [cpu_pkg::imem_addr_w-1:0]  load_addr,
    input  cpu_pkg::word_t                   load_data,
    input  logic                             start,
    output logic                             done,
    output cpu_pkg::word_t                   pc,
    output cpu_pkg::word_t                   hi,
    output cpu_pkg::word_t                   lo,
    output cpu_pkg::reg_addr_t               rs_addr,
    output cpu_pkg::reg_addr_t               rt_addr,
    input  cpu_pkg::word_t                   rs_data,
    input  cpu_pkg::word_t                   rt_data,
    output logic                             wr_en,
    output cpu_pkg::reg_addr_t               wr_addr,
    output cpu_pkg::word_t                   wr_data,
    input  cpu_pkg::word_t                   ctrl_word,
    exec_if.ctrl                             ex
);
    import cpu_pkg::*;

    logic [2:0] state;
    instr_t ir;
    word_t imem [imem_words];
    word_t dmem [dmem_words];
    word_t alu_q;
    word_t mem_q;
    word_t prod_hi_q;
    word_t mulu_hi;
    logic ovf_q;
    word_t sext_imm;
    word_t zext_imm;
    logic is_div;

    assign rs_addr = ir.r.rs;
    assign rt_addr = ir.r.rt;
    assign sext_imm = {{16{ir.i.imm[15]}}, ir.i.imm};
    assign zext_imm = {16'h0000, ir.i.imm};
    assign is_div = (ir.r.op == op_special) && (ir.r.funct == fn_div || ir.r.funct == fn_divu);

    // unsigned high word from the signed product
    assign mulu_hi = ex.mul_hi + (ex.operand_a[31] ? ex.operand_b : '0)
                   + (ex.operand_b[31] ? ex.operand_a : '0);

    // sequencer, pc, hi and lo
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            pc <= text_base;
            hi <= '0;
            lo <= '0;
            done <= 1'b0;
            ex.div_start <= 1'b0;
        end else begin
            ex.div_start <= 1'b0;
            case (state)
                st_idle: if (start) begin
                    done <= 1'b0;
                    pc <= text_base;
                    state <= st_fetch;
                end
                st_fetch: if (ctrl_word[halt_bit]) begin
                    done <= 1'b1;
                    state <= st_idle;
                end else begin
                    pc <= pc + 32'd4;
                    state <= st_decode;
                end
                st_decode: begin
                    ex.div_start <= is_div;
                    state <= st_exec;
                end
                st_exec: state <= ex.div_start ? st_div_wait : st_writeback;
                st_div_wait: if (ex.div_done) begin
                    hi <= ex.remainder;
                    lo <= ex.quotient;
                    state <= st_writeback;
                end
                st_writeback: begin
                    if (ir.r.op == op_special && ir.r.funct == fn_jr) begin
                        pc <= rs_data;
                    end else if (ir.r.op == op_special
                                 && (ir.r.funct == fn_mult || ir.r.funct == fn_multu)) begin
                        hi <= prod_hi_q;
                        lo <= alu_q;
                    end else if ((ir.i.op == op_beq && alu_q[0]) || (ir.i.op == op_bne && !alu_q[0])) begin
                        pc <= pc + {sext_imm[29:0], 2'b00};
                    end else if (ir.i.op == op_j || ir.i.op == op_jal) begin
                        pc <= {pc[31:28], ir.i[25:0], 2'b00};
                    end
                    state <= st_fetch;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // memories, instruction register and operand registers
    always_ff @(posedge clk) begin
        if (state == st_idle && load_en) begin
            imem[load_addr] <= load_data;
        end
        if (state == st_fetch) begin
            ir <= imem[pc[imem_addr_w+1:2]];
        end
        if (state == st_decode) begin
            ex.alu_op <= alu_add;
            ex.operand_a <= rs_data;
            ex.operand_b <= rt_data;
            ex.div_signed <= (ir.r.funct == fn_div);
            case (ir.r.op)
                op_special: begin
                    case (ir.r.funct)
                        fn_sub, fn_subu: ex.alu_op <= alu_sub;
                        fn_slt: ex.alu_op <= alu_slt;
                        fn_sltu: ex.alu_op <= alu_sltu;
                        fn_and: ex.alu_op <= alu_and;
                        fn_or: ex.alu_op <= alu_or;
                        fn_xor: ex.alu_op <= alu_xor;
                        fn_nor: ex.alu_op <= alu_nor;
                        fn_sllv: ex.alu_op <= alu_sll;
                        fn_srlv: ex.alu_op <= alu_srl;
                        fn_srav: ex.alu_op <= alu_sra;
                        fn_mult, fn_multu: ex.alu_op <= alu_mul;
                        default: ;
                    endcase
                    // fixed shifts take the amount from shamt
                    if (ir.r.funct == fn_sll || ir.r.funct == fn_srl || ir.r.funct == fn_sra) begin
                        ex.alu_op <= (ir.r.funct == fn_sll) ? alu_sll
                                   : (ir.r.funct == fn_srl) ? alu_srl : alu_sra;
                        ex.operand_a <= {27'h0, ir.r.shamt};
                    end
                end
                op_addi, op_addiu, op_lw, op_sw: ex.operand_b <= sext_imm;
                op_slti: begin
                    ex.alu_op <= alu_slt;
                    ex.operand_b <= sext_imm;
                end
                op_sltiu: begin
                    ex.alu_op <= alu_sltu;
                    ex.operand_b <= sext_imm;
                end
                op_andi: begin
                    ex.alu_op <= alu_and;
                    ex.operand_b <= zext_imm;
                end
                op_ori: begin
                    ex.alu_op <= alu_or;
                    ex.operand_b <= zext_imm;
                end
                op_xori: begin
                    ex.alu_op <= alu_xor;
                    ex.operand_b <= zext_imm;
                end
                op_beq, op_bne: ex.alu_op <= alu_eq;
                default: ;
            endcase
        end
        if (state == st_exec) begin
            alu_q <= ex.alu_result;
            ovf_q <= ex.overflow;
            prod_hi_q <= (ir.r.funct == fn_multu) ? mulu_hi : ex.mul_hi;
            mem_q <= dmem[ex.alu_result[11:2]];
        end
        if (state == st_writeback && ir.i.op == op_sw) begin
            dmem[alu_q[11:2]] <= rt_data;
        end
    end

    // register write port, halt clear at fetch or result at writeback
    always_comb begin
        wr_en = 1'b0;
        wr_addr = ir.i.rt;
        wr_data = alu_q;
        if (state == st_fetch && ctrl_word[halt_bit]) begin
            wr_en = 1'b1;
            wr_addr = ctrl_reg;
            wr_data = ctrl_word;
            wr_data[halt_bit] = 1'b0;
        end else if (state == st_writeback) begin
            case (ir.r.op)
                op_special: begin
                    wr_addr = ir.r.rd;
                    case (ir.r.funct)
                        // signed forms drop the write on overflow
                        fn_add, fn_sub: wr_en = !ovf_q;
                        fn_addu, fn_subu, fn_and, fn_or, fn_xor, fn_nor, fn_slt, fn_sltu,
                        fn_sll, fn_srl, fn_sra, fn_sllv, fn_srlv, fn_srav: wr_en = 1'b1;
                        fn_mfhi: begin
                            wr_en = 1'b1;
                            wr_data = hi;
                        end
                        fn_mflo: begin
                            wr_en = 1'b1;
                            wr_data = lo;
                        end
                        default: ;
                    endcase
                end
                op_addi: wr_en = !ovf_q;
                op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori: wr_en = 1'b1;
                op_lui: begin
                    wr_en = 1'b1;
                    wr_data = {ir.i.imm, 16'h0000};
                end
                op_lw: begin
                    wr_en = 1'b1;
                    wr_data = mem_q;
                end
                op_jal: begin
                    // link to r31, pc already points past the jal
                    wr_en = 1'b1;
                    wr_addr = '1;
                    wr_data = pc;
                end
                default: ;
            endcase
        end
    end

endmodule

// File: core/cpu_top.sv
`timescale 1ns/100ps

module cpu_top (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             load_en,
    input  logic [cpu_pkg::imem_addr_w-1:0]  load_addr,
    input  cpu_pkg::word_t                   load_data,
    input  logic                             start,
    output logic                             done,
    input  cpu_pkg::reg_addr_t               reg_sel,
    output cpu_pkg::word_t                   reg_value,
    output cpu_pkg::word_t                   hi,
    output cpu_pkg::word_t                   lo,
    output cpu_pkg::word_t                   pc
);
    import cpu_pkg::*;

    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    reg_addr_t wr_addr;
    word_t rs_data;
    word_t rt_data;
    word_t wr_data;
    word_t ctrl_word;
    logic wr_en;

    exec_if ex ();

    cpu_control control0 (
        .clk(clk), .reset(reset),
        .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
        .start(start), .done(done), .pc(pc), .hi(hi), .lo(lo),
        .rs_addr(rs_addr), .rt_addr(rt_addr), .rs_data(rs_data), .rt_data(rt_data),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .ctrl_word(ctrl_word), .ex(ex.ctrl)
    );

    register_file rf0 (
        .clk(clk), .reset(reset),
        .rs_addr(rs_addr), .rt_addr(rt_addr), .rs_data(rs_data), .rt_data(rt_data),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .dbg_addr(reg_sel), .dbg_data(reg_value), .ctrl_word(ctrl_word)
    );

    alu alu0 (.ex(ex.alu));

    divider div0 (.clk(clk), .reset(reset), .ex(ex.div));

endmodule

// File: test/cpu_tb_sva.sv
`timescale 1ns/100ps

module cpu_tb_sva (
    input logic                clk,
    input logic                reset,
    input logic [2:0]          state,
    input logic                done,
    input logic                div_start,
    input logic                div_done,
    input cpu_pkg::reg_addr_t  rs_addr,
    input cpu_pkg::word_t      rs_data
);
    import cpu_pkg::*;

    // one issue pulse per divide
    start_is_pulse: assert property (@(posedge clk) disable iff (reset)
        div_start |=> !div_start)
        else $error("div_start stayed high for two cycles");

    done_only_in_idle: assert property (@(posedge clk) disable iff (reset)
        state != st_idle |-> !done)
        else $error("done high while the sequencer runs");

    // r0 reads zero whatever was written to it
    zero_reg_fixed: assert property (@(posedge clk) disable iff (reset)
        rs_addr == '0 |-> rs_data == '0)
        else $error("register 0 holds a nonzero value");

    divide_latency: assert property (@(posedge clk) disable iff (reset)
        div_start |-> ##(div_cycles + 1) div_done)
        else $error("div_done missing after div_start");

endmodule

// File: test/cpu_tb.sv
`timescale 1ns/100ps

module cpu_tb;
    import cpu_pkg::*;

    localparam int max_rows = 64;
    localparam int max_len = 8;
    localparam logic [15:0] prior_val = 16'h5a5a;

    logic clk = 1'b0;
    logic reset;
    logic load_en;
    logic [imem_addr_w-1:0] load_addr;
    word_t load_data;
    logic start;
    logic done;
    reg_addr_t reg_sel;
    word_t reg_value;
    word_t hi;
    word_t lo;
    word_t pc;

    // sel 32 reads hi and sel 33 reads lo
    word_t prog [max_rows][max_len];
    int prog_len [max_rows];
    string t_name [max_rows];
    int t_sel [max_rows];
    word_t t_exp [max_rows];
    int n_rows = 0;

    word_t cur [max_len];
    int cur_len = 0;
    word_t lcg_state = 32'd85;
    int errors = 0;
    int row_errors = 0;
    int tests_ok = 0;
    int tests_bad = 0;
    int cycles = 0;
    int limit = 0;

    cpu_top dut0 (
        .clk(clk), .reset(reset),
        .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
        .start(start), .done(done), .reg_sel(reg_sel), .reg_value(reg_value),
        .hi(hi), .lo(lo), .pc(pc)
    );

    bind cpu_control cpu_tb_sva sva0 (
        .clk(clk), .reset(reset), .state(state), .done(done),
        .div_start(ex.div_start), .div_done(ex.div_done),
        .rs_addr(rs_addr), .rs_data(rs_data)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: the core did not finish within %0d cycles", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    function word_t lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function word_t rtype(logic [5:0] fn, reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
                          logic [4:0] sh);
        return {op_special, rs, rt, rd, sh, fn};
    endfunction

    function word_t itype(logic [5:0] op, reg_addr_t rs, reg_addr_t rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // jump to a word index of the program
    function word_t jump_word(logic [5:0] op, int index);
        word_t dest;
        dest = text_base + 32'(index * 4);
        return {op, dest[27:2]};
    endfunction

    function longint sext64(word_t v);
        return {{32{v[31]}}, v};
    endfunction

    function word_t alu_r_model(logic [5:0] fn, word_t a, word_t b, logic [4:0] sh,
                                word_t prior);
        longint s;
        case (fn)
            fn_add, fn_sub: begin
                s = (fn == fn_add) ? sext64(a) + sext64(b) : sext64(a) - sext64(b);
                // a sum that does not fit in 32 bits is not written
                return (s == sext64(s[31:0])) ? s[31:0] : prior;
            end
            fn_addu: return a + b;
            fn_subu: return a - b;
            fn_and: return a & b;
            fn_or: return a | b;
            fn_xor: return a ^ b;
            fn_nor: return ~(a | b);
            fn_slt: return {31'h0, $signed(a) < $signed(b)};
            fn_sltu: return {31'h0, a < b};
            fn_sll: return b << sh;
            fn_srl: return b >> sh;
            fn_sra: return word_t'($signed(b) >>> sh);
            fn_sllv: return b << a[4:0];
            fn_srlv: return b >> a[4:0];
            fn_srav: return word_t'($signed(b) >>> a[4:0]);
            default: return '0;
        endcase
    endfunction

    function word_t alu_i_model(logic [5:0] op, word_t a, logic [15:0] imm, word_t prior);
        word_t se;
        longint s;
        se = {{16{imm[15]}}, imm};
        case (op)
            op_addi: begin
                s = sext64(a) + sext64(se);
                return (s == sext64(s[31:0])) ? s[31:0] : prior;
            end
            op_addiu: return a + se;
            op_slti: return {31'h0, $signed(a) < $signed(se)};
            op_sltiu: return {31'h0, a < se};
            op_andi: return a & {16'h0, imm};
            op_ori: return a | {16'h0, imm};
            op_xori: return a ^ {16'h0, imm};
            op_lui: return {imm, 16'h0};
            default: return '0;
        endcase
    endfunction

    task muldiv_model(input logic [5:0] fn, input word_t a, input word_t b,
                      output word_t mhi, output word_t mlo);
        longint p;
        longint unsigned u;
        if (fn == fn_mult) begin
            p = sext64(a) * sext64(b);
            mhi = p[63:32];
            mlo = p[31:0];
        end else if (fn == fn_multu) begin
            u = {32'h0, a} * {32'h0, b};
            mhi = u[63:32];
            mlo = u[31:0];
        end else if (b == '0) begin
            mhi = a;
            mlo = '1;
        end else if (fn == fn_div) begin
            // quotient truncates toward zero and remainder keeps the dividend sign
            p = sext64(a) / sext64(b);
            mlo = p[31:0];
            p = sext64(a) % sext64(b);
            mhi = p[31:0];
        end else begin
            mlo = a / b;
            mhi = a % b;
        end
    endtask

    task new_prog();
        cur_len = 0;
    endtask

    task emit(word_t w);
        cur[cur_len] = w;
        cur_len++;
    endtask

    task load_reg(reg_addr_t rn, word_t v);
        emit(itype(op_lui, 5'd0, rn, v[31:16]));
        emit(itype(op_ori, rn, rn, v[15:0]));
    endtask

    // copies the current program and appends the halt on bit 3 of r27
    task add_row(string nm, int sel, word_t exp);
        for (int k = 0; k < cur_len; k++) begin
            prog[n_rows][k] = cur[k];
        end
        prog[n_rows][cur_len] = itype(op_ori, 5'd0, ctrl_reg, 16'h0008);
        prog_len[n_rows] = cur_len + 1;
        t_name[n_rows] = nm;
        t_sel[n_rows] = sel;
        t_exp[n_rows] = exp;
        n_rows++;
    endtask

    task muldiv_rows(string nm, logic [5:0] fn, word_t a, word_t b, bit via_regs);
        word_t mhi;
        word_t mlo;
        new_prog();
        load_reg(5'd8, a);
        load_reg(5'd9, b);
        emit(rtype(fn, 5'd8, 5'd9, 5'd0, 5'd0));
        emit(rtype(fn_mfhi, 5'd0, 5'd0, 5'd10, 5'd0));
        emit(rtype(fn_mflo, 5'd0, 5'd0, 5'd11, 5'd0));
        muldiv_model(fn, a, b, mhi, mlo);
        add_row({nm, "_hi"}, via_regs ? 10 : 32, mhi);
        add_row({nm, "_lo"}, via_regs ? 11 : 33, mlo);
    endtask

    task build_tests();
        logic [5:0] r_fn [16];
        string r_nm [16];
        logic [5:0] i_op [8];
        string i_nm [8];
        word_t a;
        word_t b;
        word_t t;
        r_fn = '{fn_add, fn_addu, fn_sub, fn_subu, fn_and, fn_or, fn_xor, fn_nor, fn_slt,
                 fn_sltu, fn_sll, fn_srl, fn_sra, fn_sllv, fn_srlv, fn_srav};
        r_nm = '{"add", "addu", "sub", "subu", "and", "or", "xor", "nor", "slt", "sltu",
                 "sll", "srl", "sra", "sllv", "srlv", "srav"};
        i_op = '{op_addi, op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori, op_lui};
        i_nm = '{"addi", "addiu", "slti", "sltiu", "andi", "ori", "xori", "lui"};
        for (int n = 0; n < 16; n++) begin
            a = lcg_next();
            b = lcg_next();
            t = lcg_next();
            new_prog();
            load_reg(5'd8, a);
            load_reg(5'd9, b);
            emit(itype(op_ori, 5'd0, 5'd10, prior_val));
            // fixed shifts take shamt and the rest read rs and rt
            if (r_fn[n] == fn_sll || r_fn[n] == fn_srl || r_fn[n] == fn_sra) begin
                emit(rtype(r_fn[n], 5'd0, 5'd9, 5'd10, t[4:0]));
            end else begin
                emit(rtype(r_fn[n], 5'd8, 5'd9, 5'd10, 5'd0));
            end
            add_row(r_nm[n], 10, alu_r_model(r_fn[n], a, b, t[4:0], {16'h0, prior_val}));
        end
        for (int n = 0; n < 8; n++) begin
            a = lcg_next();
            t = lcg_next();
            new_prog();
            load_reg(5'd8, a);
            emit(itype(op_ori, 5'd0, 5'd10, prior_val));
            emit(itype(i_op[n], 5'd8, 5'd10, t[15:0]));
            add_row(i_nm[n], 10, alu_i_model(i_op[n], a, t[15:0], {16'h0, prior_val}));
        end

        // overflowing signed adds keep r10 and addu wraps
        new_prog();
        load_reg(5'd8, 32'h7fff_ffff);
        load_reg(5'd9, 32'h0000_0001);
        emit(itype(op_ori, 5'd0, 5'd10, 16'h1234));
        emit(rtype(fn_add, 5'd8, 5'd9, 5'd10, 5'd0));
        add_row("add_ovf", 10, 32'h0000_1234);
        cur_len--;
        emit(rtype(fn_addu, 5'd8, 5'd9, 5'd10, 5'd0));
        add_row("addu_wrap", 10, 32'h8000_0000);
        cur_len--;
        emit(itype(op_addi, 5'd8, 5'd10, 16'h0001));
        add_row("addi_ovf", 10, 32'h0000_1234);

        a = lcg_next();
        new_prog();
        load_reg(5'd8, a);
        emit(itype(op_ori, 5'd0, 5'd10, 16'h0000));
        emit(itype(op_sw, 5'd0, 5'd8, 16'h0040));
        emit(itype(op_lw, 5'd0, 5'd10, 16'h0040));
        add_row("sw_lw", 10, a);

        // a write to r0 is dropped
        new_prog();
        emit(itype(op_ori, 5'd0, 5'd0, 16'hffff));
        add_row("r0_write", 0, 32'h0);

        // r10 sums the adds that ran
        new_prog();
        emit(itype(op_ori, 5'd0, 5'd10, 16'h0001));
        emit(itype(op_beq, 5'd0, 5'd0, 16'h0001));
        emit(itype(op_addiu, 5'd10, 5'd10, 16'h0010));
        emit(itype(op_addiu, 5'd10, 5'd10, 16'h0002));
        add_row("beq_taken", 10, 32'd3);
        cur[1] = itype(op_bne, 5'd0, 5'd0, 16'h0001);
        add_row("bne_untaken", 10, 32'd19);
        cur[1] = jump_word(op_j, 3);
        add_row("j", 10, 32'd3);

        new_prog();
        emit(itype(op_ori, 5'd0, 5'd10, 16'h0001));
        emit(jump_word(op_jal, 4));
        emit(itype(op_addiu, 5'd10, 5'd10, 16'h0002));
        emit(jump_word(op_j, 6));
        emit(itype(op_addiu, 5'd10, 5'd10, 16'h0010));
        emit(rtype(fn_jr, 5'd31, 5'd0, 5'd0, 5'd0));
        add_row("jal_jr", 10, 32'd19);
        add_row("jal_link", 31, text_base + 32'd8);

        muldiv_rows("mult", fn_mult, lcg_next(), lcg_next(), 1'b0);
        muldiv_rows("multu", fn_multu, lcg_next(), lcg_next(), 1'b0);
        muldiv_rows("div", fn_div, lcg_next(), lcg_next() >> 12, 1'b0);
        muldiv_rows("divu", fn_divu, lcg_next(), lcg_next() >> 12, 1'b0);
        muldiv_rows("mult_neg", fn_mult, lcg_next() | 32'h8000_0000,
                    lcg_next() | 32'h8000_0000, 1'b1);
        muldiv_rows("multu_neg", fn_multu, lcg_next() | 32'h8000_0000,
                    lcg_next() | 32'h8000_0000, 1'b0);
        muldiv_rows("div_neg", fn_div, lcg_next() | 32'h8000_0000, lcg_next() >> 20, 1'b1);
        muldiv_rows("divu_neg", fn_divu, lcg_next() | 32'h8000_0000, lcg_next() >> 20, 1'b0);
        muldiv_rows("div_zero", fn_div, lcg_next() | 32'h8000_0000, 32'h0, 1'b1);
        muldiv_rows("divu_zero", fn_divu, lcg_next(), 32'h0, 1'b1);
    endtask

    task check(string name, word_t expected, word_t actual);
        if (actual !== expected) begin
            $display("Fail %s expected %h actual %h", name, expected, actual);
            errors++;
            row_errors++;
        end
    endtask

    task run_test(int r);
        word_t actual;
        row_errors = 0;
        for (int k = 0; k < prog_len[r]; k++) begin
            @(posedge clk);
            load_en <= 1'b1;
            load_addr <= imem_addr_w'(k);
            load_data <= prog[r][k];
        end
        @(posedge clk);
        load_en <= 1'b0;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        // first fetch of the run
        @(negedge clk);
        check({t_name[r], " pc"}, text_base, pc);
        while (!done) @(negedge clk);
        @(posedge clk);
        reg_sel <= reg_addr_t'(t_sel[r]);
        @(negedge clk);
        actual = (t_sel[r] == 32) ? hi : (t_sel[r] == 33) ? lo : reg_value;
        check(t_name[r], t_exp[r], actual);
        if (row_errors == 0) begin
            tests_ok++;
        end else begin
            tests_bad++;
        end
        $display("test %0d %s %s", r, t_name[r], (row_errors == 0) ? "ok" : "mismatch");
    endtask

    initial begin
        reset = 1'b1;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        start = 1'b0;
        reg_sel = '0;
        build_tests();
        limit = n_rows * max_len * (4 + div_cycles + 1) + 200;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        for (int r = 0; r < n_rows; r++) begin
            run_test(r);
        end
        $display("%0d tests ok, %0d tests with errors", tests_ok, tests_bad);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: compile.f
common/cpu_pkg.sv
common/exec_if.sv
logic/register_file.sv
logic/alu.sv
logic/divider.sv
core/cpu_control.sv
core/cpu_top.sv
test/cpu_tb_sva.sv
test/cpu_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module cpu_tb -f compile.f -o cpu_sim
./obj_dir/cpu_sim 2>&1 | tee sim.log
if grep -q "Testbench failed" sim.log; then
    exit 1
fi
grep -q "Testbench passed" sim.log
